//--- verilog/dram_cache_pkg.sv
package dram_cache_pkg;

	localparam int ADDR_WIDTH     = 32;
	localparam int OFFSET_WIDTH   = 6;
	localparam int INDEX_WIDTH    = 8;
	localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
	localparam int TID_WIDTH      = 16;
	localparam int NUM_SETS       = 1 << INDEX_WIDTH;
	localparam int FIFO_DEPTH     = 4;
	localparam int FIFO_AFULL     = 2;
	localparam int FIFO_PTR_WIDTH = 2;

	typedef struct packed {
		logic [TAG_WIDTH-1:0]    tag;
		logic [INDEX_WIDTH-1:0]  index;
		logic [OFFSET_WIDTH-1:0] offset;
	} addr_fields_t;

	// one processor address, taken whole or split into cache fields
	typedef union packed {
		logic [ADDR_WIDTH-1:0] raw;
		addr_fields_t          f;
	} cache_addr_u;

	// pending request with a zero tid for writes
	typedef struct packed {
		logic                 is_write;
		logic [TID_WIDTH-1:0] tid;
		cache_addr_u          addr;
	} tag_req_t;

	typedef struct packed {
		logic                 valid;
		logic [TAG_WIDTH-1:0] tag;
	} tag_entry_t;

	typedef struct packed {
		logic                   we;
		logic [INDEX_WIDTH-1:0] index;
		tag_entry_t             entry;
	} tag_update_t;

	typedef struct packed {
		logic                 hit;
		logic                 is_write;
		logic [TID_WIDTH-1:0] tid;
		cache_addr_u          addr;
	} lookup_result_t;

endpackage

//--- verilog/index_extractor.sv
`timescale 1ns/10ps

module index_extractor (
	input  logic                                   clk,
	input  logic                                   rst_n,

	// read address channel from the processor
	input  logic [dram_cache_pkg::ADDR_WIDTH-1:0]  ar_addr_i,
	input  logic                                   ar_valid_i,
	output logic                                   ar_ready_o,

	// write address channel from the processor
	input  logic [dram_cache_pkg::ADDR_WIDTH-1:0]  aw_addr_i,
	input  logic                                   aw_valid_i,
	output logic                                   aw_ready_o,

	// index read toward the tag array
	output logic                                   idx_valid_o,
	output logic [dram_cache_pkg::INDEX_WIDTH-1:0] idx_index_o,
	input  logic                                   idx_ready_i,

	// tag FIFO write side
	input  logic                                   fifo_afull_i,
	output logic                                   fifo_push_o,
	output dram_cache_pkg::tag_req_t               fifo_entry_o
);
	import dram_cache_pkg::*;

	typedef enum logic {
		S_IDLE,
		S_REQ
	} state_t;

	state_t               state_q, state_d;
	logic                 arb_q, arb_d;
	logic [TID_WIDTH-1:0] tid_q, tid_d;
	logic                 push_q, push_d;
	logic                 idx_valid_q, idx_valid_d;
	tag_req_t             entry_q, entry_d;

	logic                 can_accept;
	logic                 sel_read;
	logic                 sel_write;
	logic                 take_read;
	logic                 take_write;

	// arb_q set means the write side goes first next time
	assign sel_read   = !aw_valid_i || !arb_q;
	assign sel_write  = !ar_valid_i || arb_q;
	assign can_accept = (state_q == S_IDLE) && !fifo_afull_i;

	assign ar_ready_o = can_accept && sel_read;
	assign aw_ready_o = can_accept && sel_write;

	assign take_read  = ar_valid_i && ar_ready_o;
	assign take_write = aw_valid_i && aw_ready_o;

	always_comb begin
		state_d     = state_q;
		arb_d       = arb_q;
		tid_d       = tid_q;
		push_d      = 1'b0;
		idx_valid_d = idx_valid_q;
		entry_d     = entry_q;

		case (state_q)
			S_IDLE: begin
				if (take_read) begin
					entry_d.is_write = 1'b0;
					entry_d.tid      = tid_q;
					entry_d.addr.raw = ar_addr_i;
					tid_d            = tid_q + 1'b1;
					arb_d            = 1'b1;
					push_d           = 1'b1;
					idx_valid_d      = 1'b1;
					state_d          = S_REQ;
				end else if (take_write) begin
					entry_d.is_write = 1'b1;
					entry_d.tid      = '0;
					entry_d.addr.raw = aw_addr_i;
					arb_d            = 1'b0;
					push_d           = 1'b1;
					idx_valid_d      = 1'b1;
					state_d          = S_REQ;
				end
			end
			S_REQ: begin
				// hold the index request until the tag array takes it
				if (idx_ready_i) begin
					idx_valid_d = 1'b0;
					state_d     = S_IDLE;
				end
			end
			default: begin
				state_d = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q     <= S_IDLE;
			arb_q       <= 1'b0;
			tid_q       <= TID_WIDTH'(1);
			push_q      <= 1'b0;
			idx_valid_q <= 1'b0;
		end else begin
			state_q     <= state_d;
			arb_q       <= arb_d;
			tid_q       <= tid_d;
			push_q      <= push_d;
			idx_valid_q <= idx_valid_d;
		end
	end

	always_ff @(posedge clk) begin
		entry_q <= entry_d;
	end

	assign idx_valid_o  = idx_valid_q;
	assign idx_index_o  = entry_q.addr.f.index;
	assign fifo_push_o  = push_q;
	assign fifo_entry_o = entry_q;

endmodule

//--- verilog/tag_fifo.sv
`timescale 1ns/10ps

module tag_fifo (
	input  logic                     clk,
	input  logic                     rst_n,

	input  logic                     push_i,
	input  dram_cache_pkg::tag_req_t entry_i,

	input  logic                     pop_i,
	output dram_cache_pkg::tag_req_t head_o,
	output logic                     not_empty_o,
	output logic                     afull_o
);
	import dram_cache_pkg::*;

	tag_req_t                mem [FIFO_DEPTH];
	logic [FIFO_PTR_WIDTH-1:0] wr_ptr_q;
	logic [FIFO_PTR_WIDTH-1:0] rd_ptr_q;
	logic [FIFO_PTR_WIDTH:0]   count_q;

	logic                      do_push;
	logic                      do_pop;

	// a push into a full queue or a pop from an empty one is dropped
	assign do_push = push_i && (count_q < FIFO_DEPTH);
	assign do_pop  = pop_i && (count_q != '0);

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr_q] <= entry_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	assign head_o      = mem[rd_ptr_q];
	assign not_empty_o = (count_q != '0);
	assign afull_o     = (count_q >= FIFO_AFULL);

endmodule

//--- verilog/tag_array.sv
`timescale 1ns/10ps

module tag_array (
	input  logic                                   clk,
	input  logic                                   rst_n,

	// index read request
	input  logic                                   idx_valid_i,
	input  logic [dram_cache_pkg::INDEX_WIDTH-1:0] idx_index_i,
	output logic                                   idx_ready_o,

	// registered read response
	output logic                                   rsp_valid_o,
	output dram_cache_pkg::tag_entry_t             rsp_entry_o,
	input  logic                                   rsp_ready_i,

	// tag install from the lookup stage
	input  dram_cache_pkg::tag_update_t            update_i
);
	import dram_cache_pkg::*;

	logic [NUM_SETS-1:0]  valid_q;
	logic [TAG_WIDTH-1:0] tag_mem [NUM_SETS];

	logic                 rsp_valid_q;
	tag_entry_t           rsp_entry_q;

	logic                 rd_fire;
	tag_entry_t           rd_entry;

	// a new read waits until the single response slot drains
	assign idx_ready_o = !rsp_valid_q;
	assign rd_fire     = idx_valid_i && idx_ready_o;

	// write-first when the update hits the index being read
	always_comb begin
		if (update_i.we && (update_i.index == idx_index_i)) begin
			rd_entry = update_i.entry;
		end else begin
			rd_entry.valid = valid_q[idx_index_i];
			rd_entry.tag   = tag_mem[idx_index_i];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (update_i.we) begin
			valid_q[update_i.index] <= update_i.entry.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (update_i.we) begin
			tag_mem[update_i.index] <= update_i.entry.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rsp_valid_q <= 1'b0;
		end else if (rd_fire) begin
			rsp_valid_q <= 1'b1;
		end else if (rsp_ready_i) begin
			rsp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rsp_entry_q <= rd_entry;
		end
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_entry_o = rsp_entry_q;

endmodule

//--- verilog/tag_lookup.sv
`timescale 1ns/10ps

module tag_lookup (
	input  logic                           clk,
	input  logic                           rst_n,

	// response from the tag array
	input  logic                           rsp_valid_i,
	input  dram_cache_pkg::tag_entry_t     rsp_entry_i,
	output logic                           rsp_ready_o,

	// oldest pending request
	input  dram_cache_pkg::tag_req_t       head_i,
	input  logic                           not_empty_i,
	output logic                           pop_o,

	// allocate on miss
	output dram_cache_pkg::tag_update_t    update_o,

	output logic                           result_valid_o,
	output dram_cache_pkg::lookup_result_t result_o
);
	import dram_cache_pkg::*;

	logic           accept;
	logic           hit;
	logic           result_valid_q;
	lookup_result_t result_q;

	// a response is only taken when its request is already queued
	assign rsp_ready_o = not_empty_i;
	assign accept      = rsp_valid_i && not_empty_i;
	assign pop_o       = accept;

	assign hit = rsp_entry_i.valid && (rsp_entry_i.tag == head_i.addr.f.tag);

	// reads and writes both install the tag on a miss
	always_comb begin
		update_o.we          = accept && !hit;
		update_o.index       = head_i.addr.f.index;
		update_o.entry.valid = 1'b1;
		update_o.entry.tag   = head_i.addr.f.tag;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid_q <= 1'b0;
		end else begin
			result_valid_q <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			result_q.hit      <= hit;
			result_q.is_write <= head_i.is_write;
			result_q.tid      <= head_i.tid;
			result_q.addr     <= head_i.addr;
		end
	end

	assign result_valid_o = result_valid_q;
	assign result_o       = result_q;

endmodule

//--- verilog/dram_cache_tag_top.sv
`timescale 1ns/10ps

module dram_cache_tag_top (
	input  logic                                  clk,
	input  logic                                  rst_n,

	input  logic [dram_cache_pkg::ADDR_WIDTH-1:0] ar_addr_i,
	input  logic                                  ar_valid_i,
	output logic                                  ar_ready_o,

	input  logic [dram_cache_pkg::ADDR_WIDTH-1:0] aw_addr_i,
	input  logic                                  aw_valid_i,
	output logic                                  aw_ready_o,

	output logic                                  result_valid_o,
	output dram_cache_pkg::lookup_result_t        result_o
);
	import dram_cache_pkg::*;

	logic                   idx_valid;
	logic [INDEX_WIDTH-1:0] idx_index;
	logic                   idx_ready;

	logic                   fifo_push;
	tag_req_t               fifo_entry;
	logic                   fifo_afull;
	logic                   fifo_pop;
	tag_req_t               fifo_head;
	logic                   fifo_not_empty;

	logic                   rsp_valid;
	tag_entry_t             rsp_entry;
	logic                   rsp_ready;

	tag_update_t            tag_update;

	index_extractor i_index_extractor (
		.clk          (clk),
		.rst_n        (rst_n),
		.ar_addr_i    (ar_addr_i),
		.ar_valid_i   (ar_valid_i),
		.ar_ready_o   (ar_ready_o),
		.aw_addr_i    (aw_addr_i),
		.aw_valid_i   (aw_valid_i),
		.aw_ready_o   (aw_ready_o),
		.idx_valid_o  (idx_valid),
		.idx_index_o  (idx_index),
		.idx_ready_i  (idx_ready),
		.fifo_afull_i (fifo_afull),
		.fifo_push_o  (fifo_push),
		.fifo_entry_o (fifo_entry)
	);

	tag_fifo i_tag_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.push_i      (fifo_push),
		.entry_i     (fifo_entry),
		.pop_i       (fifo_pop),
		.head_o      (fifo_head),
		.not_empty_o (fifo_not_empty),
		.afull_o     (fifo_afull)
	);

	tag_array i_tag_array (
		.clk         (clk),
		.rst_n       (rst_n),
		.idx_valid_i (idx_valid),
		.idx_index_i (idx_index),
		.idx_ready_o (idx_ready),
		.rsp_valid_o (rsp_valid),
		.rsp_entry_o (rsp_entry),
		.rsp_ready_i (rsp_ready),
		.update_i    (tag_update)
	);

	tag_lookup i_tag_lookup (
		.clk            (clk),
		.rst_n          (rst_n),
		.rsp_valid_i    (rsp_valid),
		.rsp_entry_i    (rsp_entry),
		.rsp_ready_o    (rsp_ready),
		.head_i         (fifo_head),
		.not_empty_i    (fifo_not_empty),
		.pop_o          (fifo_pop),
		.update_o       (tag_update),
		.result_valid_o (result_valid_o),
		.result_o       (result_o)
	);

endmodule

//--- verification/dram_cache_tag_checker.sv
`timescale 1ns/10ps

module dram_cache_tag_checker (
	input logic clk,
	input logic rst_n,
	input logic idx_valid_i,
	input logic idx_ready_i,
	input logic fifo_push_i,
	input logic fifo_pop_i,
	input logic result_valid_i
);
	import dram_cache_pkg::*;

	logic [FIFO_PTR_WIDTH:0] occupancy_q;

	// shadow occupancy of the tag FIFO, built from the push and pop pulses
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			occupancy_q <= '0;
		end else begin
			case ({fifo_push_i, fifo_pop_i})
				2'b10:   occupancy_q <= occupancy_q + 1'b1;
				2'b01:   occupancy_q <= occupancy_q - 1'b1;
				default: occupancy_q <= occupancy_q;
			endcase
		end
	end

	idx_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
		idx_valid_i && !idx_ready_i |=> idx_valid_i)
		else $error("index request withdrawn before the tag array accepted it");

	no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_push_i |-> (occupancy_q < FIFO_DEPTH))
		else $error("tag FIFO pushed while full");

	no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_pop_i |-> (occupancy_q != '0))
		else $error("tag FIFO popped while empty");

	// results are single-cycle pulses
	result_is_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid_i |=> !result_valid_i)
		else $error("result valid held for two cycles");

endmodule

//--- verification/tb_dram_cache_tag.sv
`timescale 1ns/10ps

module tb_dram_cache_tag;
	import dram_cache_pkg::*;

	localparam int          CLK_PERIOD = 10;
	localparam int          RAND_COUNT = 80;
	localparam logic [31:0] RAND_SEED  = 32'h6c6d_0062;

	// the hit columns hold the expected lookup outcome per channel
	typedef struct packed {
		logic                  ar_valid;
		logic [ADDR_WIDTH-1:0] ar_addr;
		logic                  ar_hit;
		logic                  aw_valid;
		logic [ADDR_WIDTH-1:0] aw_addr;
		logic                  aw_hit;
	} stim_t;

	logic                  clk;
	logic                  rst_n;
	logic [ADDR_WIDTH-1:0] ar_addr_i;
	logic                  ar_valid_i;
	logic                  ar_ready_o;
	logic [ADDR_WIDTH-1:0] aw_addr_i;
	logic                  aw_valid_i;
	logic                  aw_ready_o;
	logic                  result_valid_o;
	lookup_result_t        result_o;

	stim_t                 stim_q[$];
	lookup_result_t        expected_q[$];
	logic [NUM_SETS-1:0]   ref_valid;
	logic [TAG_WIDTH-1:0]  ref_tag [NUM_SETS];
	logic [TID_WIDTH-1:0]  ref_tid;
	logic                  ref_arb;
	int                    accepted;
	int                    results_seen;
	bit                    pass_printed;
	bit                    fail_printed;

	dram_cache_tag_top i_dut (.*);

	bind dram_cache_tag_top dram_cache_tag_checker i_checker (
		.clk            (clk),
		.rst_n          (rst_n),
		.idx_valid_i    (idx_valid),
		.idx_ready_i    (idx_ready),
		.fifo_push_i    (fifo_push),
		.fifo_pop_i     (fifo_pop),
		.result_valid_i (result_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_with_failure(input string msg);
		fail_printed = 1'b1;
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp)
			else stop_with_failure($sformatf("error at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, exp, got));
	endtask

	function automatic logic [ADDR_WIDTH-1:0] line_addr(input int tag, input int index,
		input int offset);
		cache_addr_u a;
		a.f.tag    = TAG_WIDTH'(tag);
		a.f.index  = INDEX_WIDTH'(index);
		a.f.offset = OFFSET_WIDTH'(offset);
		return a.raw;
	endfunction

	task automatic add_row(input logic arv, input logic [31:0] ara, input logic arh,
		input logic awv, input logic [31:0] awa, input logic awh);
		stim_q.push_back('{arv, ara, arh, awv, awa, awh});
	endtask

	task automatic load_table();
		// repeat read to one line, then same line at another offset
		add_row(1, line_addr(1, 5, 0), 0, 0, '0, 0);
		add_row(1, line_addr(1, 5, 4), 1, 0, '0, 0);
		// write allocates, read after it hits
		add_row(0, '0, 0, 1, line_addr(2, 9, 0), 0);
		add_row(1, line_addr(2, 9, 8), 1, 0, '0, 0);
		// two tags fighting over set 12
		add_row(1, line_addr(3, 12, 0), 0, 0, '0, 0);
		add_row(1, line_addr(4, 12, 0), 0, 0, '0, 0);
		add_row(1, line_addr(3, 12, 0), 0, 0, '0, 0);
		add_row(0, '0, 0, 1, line_addr(4, 12, 0), 0);
		add_row(1, line_addr(3, 12, 0), 0, 0, '0, 0);
		// both channels at once
		add_row(1, line_addr(5, 20, 0), 0, 1, line_addr(6, 21, 0), 0);
		add_row(1, line_addr(6, 21, 16), 1, 1, line_addr(5, 20, 2), 1);
		add_row(1, line_addr(7, 20, 0), 0, 1, line_addr(7, 21, 0), 0);
	endtask

	function automatic stim_t random_entry();
		stim_t s;
		int    v;
		v = $urandom_range(3, 1);
		s.ar_valid = v[0];
		s.aw_valid = v[1];
		// small tag and index range so hits and evictions both happen
		s.ar_addr  = line_addr($urandom_range(3), $urandom_range(3), $urandom_range(63));
		s.aw_addr  = line_addr($urandom_range(3), $urandom_range(3), $urandom_range(63));
		s.ar_hit   = 1'b0;
		s.aw_hit   = 1'b0;
		return s;
	endfunction

	// reference direct-mapped tags that allocate on every miss
	task automatic record_accept(input logic is_wr, input logic [31:0] addr,
		input logic use_table, input logic table_hit);
		cache_addr_u    a;
		lookup_result_t exp;
		logic           model_hit;
		a.raw     = addr;
		model_hit = ref_valid[a.f.index] && (ref_tag[a.f.index] == a.f.tag);
		if (!model_hit) begin
			ref_valid[a.f.index] = 1'b1;
			ref_tag[a.f.index]   = a.f.tag;
		end
		exp.hit      = use_table ? table_hit : model_hit;
		exp.is_write = is_wr;
		exp.tid      = is_wr ? '0 : ref_tid;
		exp.addr     = a;
		if (!is_wr) begin
			ref_tid = ref_tid + 1'b1;
		end
		ref_arb = !is_wr;
		expected_q.push_back(exp);
		accepted++;
	endtask

	// holds each valid until its channel accepts, like a processor master would
	task automatic apply_entry(input stim_t e, input logic use_table);
		logic pend_r;
		logic pend_w;
		logic acc_r;
		logic acc_w;
		pend_r = e.ar_valid;
		pend_w = e.aw_valid;
		while (pend_r || pend_w) begin
			@(negedge clk);
			ar_valid_i = pend_r;
			ar_addr_i  = e.ar_addr;
			aw_valid_i = pend_w;
			aw_addr_i  = e.aw_addr;
			#1;
			acc_r = ar_valid_i && ar_ready_o;
			acc_w = aw_valid_i && aw_ready_o;
			assert (!(acc_r && acc_w))
				else stop_with_failure("both address channels accepted in the same cycle");
			if (pend_r && pend_w && (acc_r || acc_w)) begin
				assert (acc_w == ref_arb)
					else stop_with_failure("arbiter picked the wrong channel with both valid");
			end
			if (acc_r) begin
				record_accept(1'b0, e.ar_addr, use_table, e.ar_hit);
				pend_r = 1'b0;
			end else if (acc_w) begin
				record_accept(1'b1, e.aw_addr, use_table, e.aw_hit);
				pend_w = 1'b0;
			end
		end
	endtask

	initial begin
		lookup_result_t exp;
		forever begin
			@(negedge clk);
			if (rst_n === 1'b1 && result_valid_o === 1'b1) begin
				assert (expected_q.size() > 0)
					else stop_with_failure("result arrived with no accepted request pending");
				exp = expected_q.pop_front();
				check_value("result_o.hit", 32'(exp.hit), 32'(result_o.hit));
				check_value("result_o.is_write", 32'(exp.is_write), 32'(result_o.is_write));
				check_value("result_o.tid", 32'(exp.tid), 32'(result_o.tid));
				check_value("result_o.addr", exp.addr.raw, result_o.addr.raw);
				results_seen++;
			end
		end
	end

	initial begin
		int limit_ns;
		#1;
		limit_ns = (stim_q.size() + RAND_COUNT) * 12 * CLK_PERIOD + 100 * CLK_PERIOD;
		#(limit_ns);
		stop_with_failure("timeout: the run did not finish within the expected time");
	end

	initial begin
		int drain_cycles;
		rst_n        = 1'b0;
		ar_valid_i   = 1'b0;
		ar_addr_i    = '0;
		aw_valid_i   = 1'b0;
		aw_addr_i    = '0;
		ref_valid    = '0;
		ref_tid      = TID_WIDTH'(1);
		ref_arb      = 1'b0;
		accepted     = 0;
		results_seen = 0;
		load_table();
		void'($urandom(RAND_SEED));
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		foreach (stim_q[i]) begin
			apply_entry(stim_q[i], 1'b1);
		end
		for (int n = 0; n < RAND_COUNT; n++) begin
			apply_entry(random_entry(), 1'b0);
		end
		@(negedge clk);
		ar_valid_i = 1'b0;
		aw_valid_i = 1'b0;
		drain_cycles = 0;
		while (results_seen != accepted && drain_cycles < 50) begin
			@(negedge clk);
			drain_cycles++;
		end
		// extra idle cycles catch any surplus result
		repeat (10) @(negedge clk);
		if (results_seen == accepted && expected_q.size() == 0) begin
			pass_printed = 1'b1;
			$display("TEST PASS");
			$finish;
		end else begin
			stop_with_failure($sformatf("%0d requests accepted but %0d results seen",
				accepted, results_seen));
		end
	end

	final begin
		if (!pass_printed && !fail_printed) begin
			$display("TEST FAIL");
		end
	end

endmodule

//--- sim.f
verilog/dram_cache_pkg.sv
verilog/index_extractor.sv
verilog/tag_fifo.sv
verilog/tag_array.sv
verilog/tag_lookup.sv
verilog/dram_cache_tag_top.sv
verification/dram_cache_tag_checker.sv
verification/tb_dram_cache_tag.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_dram_cache_tag
FILELIST  := sim.f
BUILD_DIR := obj_dir
SIM_LOG   := sim.log
PASS_TEXT := TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@grep -q "$(PASS_TEXT)" $(SIM_LOG) || (echo "simulation failed, see $(SIM_LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)
